// File: Bender.yml
package:
  name: mmu_xlate

sources:
  - include_dirs:
      - logic
    files:
      - logic/mmu_pkg.sv
      - logic/sram_sp.sv
      - logic/tlb.sv
      - logic/walk_timer.sv
      - logic/xlate_ctrl.sv
      - logic/mmu_xlate.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_clock.sv
      - test/mmu_xlate_checker.sv
      - test/mmu_xlate_tb.sv

// File: logic/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// ------------------------------------------------------------
// address widths
// ------------------------------------------------------------
`define MMU_VA_WIDTH      32
`define MMU_PA_WIDTH      34

// ------------------------------------------------------------
// tlb geometry
// ------------------------------------------------------------
`define TLB_VPN_WIDTH     20
`define TLB_PTE_WIDTH     32
`define TLB_WAY_NUM       4
`define TLB_DEPTH         32     // sets per way.
`define TLB_IDX_WIDTH     5      // vpn[14:10].
`define TLB_TAG_WIDTH     15     // vpn[19:15] plus vpn0.

// ------------------------------------------------------------
// page walk
// ------------------------------------------------------------
`define MMU_WALK_TIMEOUT  64     // wait cycles per memory read.

`endif

// File: logic/mmu_pkg.sv
`include "mmu_cfg.svh"

package mmu_pkg;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef logic [`TLB_TAG_WIDTH-1:0] tlb_tag_t;

    // 0 is the victim, all ones the most recent.
    typedef logic [$clog2(`TLB_WAY_NUM)-1:0] tlb_ord_t;

    typedef enum logic [2:0] {
        XS_IDLE,
        XS_LOOKUP,
        XS_WALK_L1,
        XS_WALK_L0,
        XS_REFILL,
        XS_DONE
    } xlate_state_e;

    function automatic logic is_leaf(pte_t p);
        return p.r | p.x;
    endfunction

endpackage

// File: logic/mmu_xlate.sv
`include "mmu_cfg.svh"

module mmu_xlate (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic                        req,
    input  logic [`MMU_VA_WIDTH-1:0]    vaddr,
    input  logic [`MMU_PA_WIDTH-13:0]   ptbr,
    input  logic                        flush,
    output logic                        busy,
    output logic                        done,
    output logic                        fault,
    output logic [`MMU_PA_WIDTH-1:0]    paddr,

    output logic                        mem_rd,
    output logic [`MMU_PA_WIDTH-1:0]    mem_addr,
    input  logic                        mem_rvalid,
    input  logic [`TLB_PTE_WIDTH-1:0]   mem_rdata
);

    import mmu_pkg::*;

    logic                      tlb_cs;
    logic                      tlb_we;
    logic [`TLB_VPN_WIDTH-1:0] tlb_vpn;
    logic                      tlb_spage;
    pte_t                      tlb_pte_in;
    logic                      tlb_hit;
    pte_t                      tlb_pte;
    logic                      timer_run;
    logic                      timer_expired;

    xlate_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .req           (req),
        .vaddr         (vaddr),
        .ptbr          (ptbr),
        .busy          (busy),
        .done          (done),
        .fault         (fault),
        .paddr         (paddr),
        .mem_rd        (mem_rd),
        .mem_addr      (mem_addr),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (pte_t'(mem_rdata)),
        .tlb_cs        (tlb_cs),
        .tlb_we        (tlb_we),
        .tlb_vpn       (tlb_vpn),
        .tlb_spage     (tlb_spage),
        .tlb_pte_in    (tlb_pte_in),
        .tlb_hit       (tlb_hit),
        .tlb_pte       (tlb_pte),
        .timer_run     (timer_run),
        .timer_expired (timer_expired)
    );

    walk_timer u_timer (
        .clk     (clk),
        .rstn    (rstn),
        .run     (timer_run),
        .expired (timer_expired)
    );

    tlb u_tlb (
        .clk     (clk),
        .rstn    (rstn),
        .cs      (tlb_cs),
        .vpn     (tlb_vpn),
        .we      (tlb_we),
        .spage   (tlb_spage),
        .pte_in  (tlb_pte_in),
        .flush   (flush),           // straight from the port.
        .pte_hit (tlb_hit),
        .pte_out (tlb_pte)
    );

endmodule

// File: logic/sram_sp.sv
`include "mmu_cfg.svh"

module sram_sp #(
    parameter type payload_t = logic
) (
    input  logic                      clk,
    input  logic                      cs,
    input  logic                      we,
    input  logic [`TLB_IDX_WIDTH-1:0] addr,
    input  payload_t                  din,
    output payload_t                  dout
);

    payload_t mem [`TLB_DEPTH];

    // dout keeps the last read word.
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= din;
            end
            else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// File: logic/tlb.sv
`include "mmu_cfg.svh"

module tlb (
    input  logic                      clk,
    input  logic                      rstn,

    input  logic                      cs,
    input  logic [`TLB_VPN_WIDTH-1:0] vpn,
    input  logic                      we,
    input  logic                      spage,
    input  mmu_pkg::pte_t             pte_in,
    input  logic                      flush,

    output logic                      pte_hit,
    output mmu_pkg::pte_t             pte_out
);

    import mmu_pkg::*;

    logic [`TLB_IDX_WIDTH-1:0] idx;
    logic [`TLB_IDX_WIDTH-1:0] idx_q;
    tlb_tag_t                  tag;
    tlb_tag_t                  tag_q;
    logic [9:0]                vpn0_q;
    logic                      rd_q;
    logic                      wr;
    logic                      hit_upd;
    logic [`TLB_WAY_NUM-1:0]   hit;
    logic [`TLB_WAY_NUM-1:0]   victim;
    logic [`TLB_WAY_NUM-1:0]   spg_hit;
    tlb_ord_t                  ord_h [`TLB_WAY_NUM];
    tlb_ord_t                  hit_ord;
    pte_t                      pte_way [`TLB_WAY_NUM];

    assign idx     = vpn[10 +: `TLB_IDX_WIDTH];
    assign tag     = {vpn[`TLB_VPN_WIDTH-1 -: `TLB_TAG_WIDTH-10], vpn[9:0] & {10{~spage}}};
    assign wr      = cs && we;
    assign pte_hit = |hit;
    assign hit_upd = rd_q && pte_hit;

    // ------------------------------------------------------------
    // read side latches
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_q <= 1'b0;
        end
        else begin
            rd_q <= cs && !we;
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !we) begin
            tag_q  <= tag;
            vpn0_q <= vpn[9:0];
            idx_q  <= idx;
        end
    end

    always_comb begin
        hit_ord = '0;
        for (int i = 0; i < `TLB_WAY_NUM; i++) begin
            if (hit[i]) begin
                hit_ord = hit_ord | ord_h[i];
            end
        end
    end

    // superpage hit takes ppn0 from the request.
    always_comb begin
        pte_out = '0;
        for (int i = 0; i < `TLB_WAY_NUM; i++) begin
            if (hit[i]) begin
                pte_out = pte_t'(pte_out | pte_way[i]);
            end
        end
        if (|spg_hit) begin
            pte_out.ppn0 = pte_out.ppn0 | vpn0_q;
        end
    end

    // ------------------------------------------------------------
    // ways
    // ------------------------------------------------------------
    for (genvar g = 0; g < `TLB_WAY_NUM; g++) begin : g_way
        logic [`TLB_DEPTH-1:0] valid;
        logic [`TLB_DEPTH-1:0] spg;
        tlb_ord_t              order [`TLB_DEPTH];
        logic                  valid_q;
        logic                  spg_q;
        tlb_tag_t              tag_out;

        assign ord_h[g]   = order[idx_q];
        assign victim[g]  = (order[idx] == '0);
        assign hit[g]     = rd_q && valid_q &&
                            tag_out == {tag_q[`TLB_TAG_WIDTH-1:10], tag_q[9:0] & {10{~spg_q}}};
        assign spg_hit[g] = hit[g] && spg_q;

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid <= '0;
                spg   <= '0;
                for (int i = 0; i < `TLB_DEPTH; i++) begin
                    order[i] <= tlb_ord_t'(g);
                end
            end
            else if (flush) begin
                valid <= '0;
                for (int i = 0; i < `TLB_DEPTH; i++) begin
                    order[i] <= tlb_ord_t'(g);
                end
            end
            else if (wr) begin
                if (victim[g]) begin
                    valid[idx] <= 1'b1;
                    spg[idx]   <= spage;
                    order[idx] <= '1;
                end
                else begin
                    order[idx] <= order[idx] - 1'b1; // everyone else is above 0.
                end
            end
            else if (hit_upd) begin
                if (hit[g]) begin
                    order[idx_q] <= '1;
                end
                else if (order[idx_q] > hit_ord) begin
                    order[idx_q] <= order[idx_q] - 1'b1;
                end
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= 1'b0;
                spg_q   <= 1'b0;
            end
            else if (cs && !we) begin
                valid_q <= valid[idx];
                spg_q   <= spg[idx];
            end
        end

        sram_sp #(.payload_t(tlb_tag_t)) u_tag_ram (
            .clk  (clk),
            .cs   (cs),
            .we   (wr && victim[g]),
            .addr (idx),
            .din  (tag),
            .dout (tag_out)
        );

        sram_sp #(.payload_t(pte_t)) u_pte_ram (
            .clk  (clk),
            .cs   (cs),
            .we   (wr && victim[g]),
            .addr (idx),
            .din  (pte_in),
            .dout (pte_way[g])
        );
    end

endmodule

// File: logic/walk_timer.sv
`include "mmu_cfg.svh"

module walk_timer (
    input  logic clk,
    input  logic rstn,
    input  logic run,
    output logic expired
);

    logic [$clog2(`MMU_WALK_TIMEOUT+1)-1:0] cnt;

    assign expired = (cnt == `MMU_WALK_TIMEOUT);

    // saturates at the timeout.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end
        else if (!run) begin
            cnt <= '0;            // new request, full budget.
        end
        else if (!expired) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: logic/xlate_ctrl.sv
`include "mmu_cfg.svh"

module xlate_ctrl (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic                        req,
    input  logic [`MMU_VA_WIDTH-1:0]    vaddr,
    input  logic [`MMU_PA_WIDTH-13:0]   ptbr,
    output logic                        busy,
    output logic                        done,
    output logic                        fault,
    output logic [`MMU_PA_WIDTH-1:0]    paddr,

    output logic                        mem_rd,
    output logic [`MMU_PA_WIDTH-1:0]    mem_addr,
    input  logic                        mem_rvalid,
    input  mmu_pkg::pte_t               mem_rdata,

    output logic                        tlb_cs,
    output logic                        tlb_we,
    output logic [`TLB_VPN_WIDTH-1:0]   tlb_vpn,
    output logic                        tlb_spage,
    output mmu_pkg::pte_t               tlb_pte_in,
    input  logic                        tlb_hit,
    input  mmu_pkg::pte_t               tlb_pte,

    output logic                        timer_run,
    input  logic                        timer_expired
);

    import mmu_pkg::*;

    xlate_state_e             state;
    logic [`MMU_VA_WIDTH-1:0] vaddr_q;
    pte_t                     pte_q;
    logic                     spage_q;
    logic                     refill_rd;   // second refill cycle re-reads.
    logic                     pte_inv;
    logic                     pte_leaf;
    logic                     pte_misal;

    assign pte_inv   = !mem_rdata.v;
    assign pte_leaf  = is_leaf(mem_rdata);
    assign pte_misal = pte_leaf && (mem_rdata.ppn0 != '0);

    assign busy      = (state != XS_IDLE) && (state != XS_DONE);
    assign timer_run = (state == XS_WALK_L1 || state == XS_WALK_L0) && !mem_rd;

    // ------------------------------------------------------------
    // tlb port
    // ------------------------------------------------------------
    assign tlb_cs     = (state == XS_IDLE && req) || state == XS_REFILL;
    assign tlb_we     = (state == XS_REFILL) && !refill_rd;
    assign tlb_vpn    = (state == XS_IDLE) ? vaddr[31:12] : vaddr_q[31:12];
    assign tlb_spage  = spage_q && tlb_we;
    assign tlb_pte_in = pte_q;

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= XS_IDLE;
            done      <= 1'b0;
            fault     <= 1'b0;
            mem_rd    <= 1'b0;
            spage_q   <= 1'b0;
            refill_rd <= 1'b0;
        end
        else begin
            done   <= 1'b0;
            fault  <= 1'b0;
            mem_rd <= 1'b0;
            case (state)
                XS_IDLE: begin
                    if (req) begin
                        state <= XS_LOOKUP;
                    end
                end
                XS_LOOKUP: begin
                    if (tlb_hit) begin
                        state <= XS_DONE;
                        done  <= 1'b1;
                    end
                    else begin
                        state  <= XS_WALK_L1;
                        mem_rd <= 1'b1;
                    end
                end
                XS_WALK_L1: begin
                    if (mem_rvalid) begin
                        if (pte_inv || pte_misal) begin
                            state <= XS_DONE;
                            done  <= 1'b1;
                            fault <= 1'b1;
                        end
                        else if (pte_leaf) begin
                            state   <= XS_REFILL;
                            spage_q <= 1'b1;           // 4 MiB page.
                        end
                        else begin
                            state  <= XS_WALK_L0;
                            mem_rd <= 1'b1;
                        end
                    end
                    else if (timer_expired) begin
                        state <= XS_DONE;
                        done  <= 1'b1;
                        fault <= 1'b1;
                    end
                end
                XS_WALK_L0: begin
                    if (mem_rvalid) begin
                        if (pte_inv || !pte_leaf) begin
                            state <= XS_DONE;
                            done  <= 1'b1;
                            fault <= 1'b1;
                        end
                        else begin
                            state   <= XS_REFILL;
                            spage_q <= 1'b0;
                        end
                    end
                    else if (timer_expired) begin
                        state <= XS_DONE;
                        done  <= 1'b1;
                        fault <= 1'b1;
                    end
                end
                XS_REFILL: begin
                    refill_rd <= !refill_rd;
                    if (refill_rd) begin
                        state <= XS_LOOKUP;
                    end
                end
                XS_DONE: begin
                    state <= XS_IDLE;
                end
                default: begin
                    state <= XS_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // addresses and data
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == XS_IDLE && req) begin
            vaddr_q <= vaddr;
        end
        if (state == XS_LOOKUP) begin
            if (tlb_hit) begin
                paddr <= {tlb_pte.ppn1, tlb_pte.ppn0, vaddr_q[11:0]};
            end
            else begin
                mem_addr <= {ptbr, vaddr_q[31:22], 2'b00};   // root table, vpn1.
            end
        end
        if (state == XS_WALK_L1 && mem_rvalid) begin
            mem_addr <= {mem_rdata.ppn1, mem_rdata.ppn0, vaddr_q[21:12], 2'b00};
        end
        if ((state == XS_WALK_L1 || state == XS_WALK_L0) && mem_rvalid) begin
            pte_q <= mem_rdata;
        end
    end

endmodule

// File: mmu_xlate.f
+incdir+logic
logic/mmu_pkg.sv
logic/sram_sp.sv
logic/tlb.sv
logic/walk_timer.sv
logic/xlate_ctrl.sv
logic/mmu_xlate.sv
test/tb_clock.sv
test/mmu_xlate_checker.sv
test/mmu_xlate_tb.sv

// File: test/mmu_xlate_checker.sv
module mmu_xlate_checker (
    input logic clk,
    input logic rstn,
    input logic busy,
    input logic done,
    input logic fault,
    input logic mem_rd
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;    // read by the testbench.

    a_done_rd_excl: assert property (@(posedge clk) disable iff (!rstn) !(done && mem_rd))
        else begin
            $error("done and mem_rd high in the same cycle");
            fail_cnt++;
        end

    a_rd_busy: assert property (@(posedge clk) disable iff (!rstn) mem_rd |-> busy)
        else begin
            $error("mem_rd high while busy is low");
            fail_cnt++;
        end

    a_fault_done: assert property (@(posedge clk) disable iff (!rstn) fault |-> done)
        else begin
            $error("fault high without done");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_cnt++;
        end

endmodule

bind mmu_xlate mmu_xlate_checker u_checker (
    .clk    (clk),
    .rstn   (rstn),
    .busy   (busy),
    .done   (done),
    .fault  (fault),
    .mem_rd (mem_rd)
);

// File: test/mmu_xlate_tb.sv
`include "mmu_cfg.svh"

module mmu_xlate_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          REQ_LIMIT  = 4 * `MMU_WALK_TIMEOUT;
    localparam logic [21:0] ROOT_PPN   = 22'h00100;
    localparam logic [7:0]  PTR_FLAGS  = 8'h01;             // v only.
    localparam logic [7:0]  LEAF_FLAGS = 8'hcf;             // d a x w r v.
    localparam logic [31:0] VA_4K      = 32'h0040_3abc;     // set 1.
    localparam logic [31:0] VA_4K2     = 32'h0040_7def;
    localparam logic [21:0] L0_TBL     = 22'h00200;
    localparam logic [31:0] VA_SP      = 32'h0080_5123;     // set 2.
    localparam logic [31:0] VA_SP2     = 32'h0081_7456;
    localparam logic [21:0] SP_PPN     = {12'h0a5, 10'h000};
    localparam logic [21:0] LRU_TBL    = 22'h00300;         // set 3.
    localparam logic [31:0] VA_INV     = 32'h0100_0040;
    localparam logic [31:0] VA_MIS     = 32'h0140_0000;
    localparam logic [31:0] VA_TMO     = 32'h0180_0000;

    logic        clk;
    logic        rstn;
    logic        req;
    logic [31:0] vaddr;
    logic [21:0] ptbr;
    logic        flush;
    logic        busy;
    logic        done;
    logic        fault;
    logic [33:0] paddr;
    logic        mem_rd;
    logic [33:0] mem_addr;
    logic        mem_rvalid = 1'b0;
    logic [31:0] mem_rdata = '0;

    // page table memory model.
    logic [31:0] pt_mem [logic [33:0]];
    logic [33:0] rd_log [$];
    logic        mem_on;
    logic        pend;
    logic [33:0] pend_addr;
    logic [1:0]  wait_cnt;
    integer      seed = 32'h7da1;

    // results of the last request.
    logic        res_done;
    logic        res_fault;
    logic [33:0] res_pa;
    int          res_edges;
    int          res_reads;
    int          rd_base;

    tb_clock u_clock (
        .clk (clk)
    );

    mmu_xlate u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .vaddr      (vaddr),
        .ptbr       (ptbr),
        .flush      (flush),
        .busy       (busy),
        .done       (done),
        .fault      (fault),
        .paddr      (paddr),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    // ----------------------------------------------------------
    // memory model
    // ----------------------------------------------------------
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_rvalid <= 1'b0;
            pend       <= 1'b0;
            wait_cnt   <= '0;
        end
        else begin
            mem_rvalid <= 1'b0;
            if (pend && wait_cnt == 0) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= pt_read(pend_addr);
                pend       <= 1'b0;
            end
            else if (pend) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (mem_rd) begin
                rd_log.push_back(mem_addr);
                if (mem_on) begin
                    pend      <= 1'b1;
                    pend_addr <= mem_addr;
                    wait_cnt  <= 2'($random(seed));    // 1 to 4 cycles.
                end
            end
        end
    end

    always @(negedge clk) begin
        assert (u_dut.u_checker.fail_cnt == 0)
            else fail_now("protocol assertion failed in the bound checker");
    end

    function automatic logic [31:0] pt_read(input logic [33:0] a);
        if (pt_mem.exists(a)) begin
            return pt_mem[a];
        end
        return '0;                     // unmapped reads as invalid.
    endfunction

    function automatic logic [33:0] l1_addr(input logic [31:0] va);
        return {ROOT_PPN, 12'h000} + {va[31:22], 2'b00};
    endfunction

    function automatic logic [33:0] l0_addr(input logic [21:0] tbl, input logic [31:0] va);
        return {tbl, 12'h000} + {va[21:12], 2'b00};
    endfunction

    function automatic logic [21:0] page_ppn(input logic [31:0] va);
        return {va[31:22] + 12'h120, va[21:12] ^ 10'h155};
    endfunction

    function automatic logic [33:0] page_pa(input logic [31:0] va);
        return {page_ppn(va), va[11:0]};
    endfunction

    function automatic logic [31:0] lru_va(input int i);
        return {10'd3, 10'(i + 1), 12'h080};
    endfunction

    task automatic map_page(input logic [31:0] va, input logic [21:0] tbl);
        pt_mem[l1_addr(va)]      = {tbl, 2'b00, PTR_FLAGS};
        pt_mem[l0_addr(tbl, va)] = {page_ppn(va), 2'b00, LEAF_FLAGS};
    endtask

    task automatic build_tables();
        int i;
        map_page(VA_4K, L0_TBL);
        map_page(VA_4K2, L0_TBL);
        pt_mem[l1_addr(VA_SP)] = {SP_PPN, 2'b00, LEAF_FLAGS};
        for (i = 0; i < 5; i++) begin
            map_page(lru_va(i), LRU_TBL);
        end
        pt_mem[l1_addr(VA_INV)] = {22'h3abcd, 2'b00, 8'hce};
        pt_mem[l1_addr(VA_MIS)] = {12'h0b0, 10'h001, 2'b00, LEAF_FLAGS};
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string test, input string what,
                            input logic [33:0] exp, input logic [33:0] act);
        assert (act === exp)
            else fail_now($sformatf("ERR %s %s: expected %0h, actual %0h", test, what, exp, act));
    endtask

    // ----------------------------------------------------------
    // request and checks
    // ----------------------------------------------------------
    task automatic run_xlate(input string test, input logic [31:0] va, input int limit);
        int n;
        rd_base  = rd_log.size();
        n        = 0;
        res_done = 1'b0;
        @(posedge clk);
        vaddr <= va;
        req   <= 1'b1;
        while (!res_done && n < limit) begin
            @(posedge clk);
            req <= 1'b0;
            n++;
            @(negedge clk);
            res_done = done;
            if (!res_done) begin
                check_eq(test, "busy", 1, busy);
            end
        end
        assert (res_done)
            else fail_now($sformatf("%s: no done within %0d cycles", test, limit));
        res_edges = n;
        res_fault = fault;
        res_pa    = paddr;
        res_reads = rd_log.size() - rd_base;
    endtask

    task automatic expect_xlate(input string test, input logic [31:0] va,
                                input logic [33:0] exp_pa, input int exp_reads);
        run_xlate(test, va, REQ_LIMIT);
        check_eq(test, "fault", 0, res_fault);
        check_eq(test, "paddr", exp_pa, res_pa);
        check_eq(test, "mem_rd count", exp_reads, res_reads);
        if (exp_reads == 0) begin
            check_eq(test, "edges to done", 2, res_edges);
        end
    endtask

    task automatic expect_fault(input string test, input logic [31:0] va, input int limit);
        run_xlate(test, va, limit);
        check_eq(test, "fault", 1, res_fault);
        check_eq(test, "mem_rd count", 1, res_reads);    // a fault is never cached.
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    task automatic test_reset_first_miss();
        @(negedge clk);
        check_eq("reset_first_miss", "busy", 0, busy);
        check_eq("reset_first_miss", "done", 0, done);
        check_eq("reset_first_miss", "mem_rd", 0, mem_rd);
        expect_xlate("reset_first_miss", VA_4K, page_pa(VA_4K), 2);
        check_eq("reset_first_miss", "first mem_addr", l1_addr(VA_4K), rd_log[rd_base]);
    endtask

    task automatic test_walk_hit();
        expect_xlate("walk_hit", VA_4K2, page_pa(VA_4K2), 2);
        check_eq("walk_hit", "l1 mem_addr", l1_addr(VA_4K2), rd_log[rd_base]);
        check_eq("walk_hit", "l0 mem_addr", l0_addr(L0_TBL, VA_4K2), rd_log[rd_base + 1]);
        expect_xlate("walk_hit_repeat", VA_4K2, page_pa(VA_4K2), 0);
    endtask

    task automatic test_superpage();
        expect_xlate("superpage", VA_SP, {SP_PPN[21:10], VA_SP[21:0]}, 1);
        expect_xlate("superpage_other", VA_SP2, {SP_PPN[21:10], VA_SP2[21:0]}, 0);
    endtask

    task automatic test_lru();
        int i;
        for (i = 0; i < 4; i++) begin
            expect_xlate("lru_fill", lru_va(i), page_pa(lru_va(i)), 2);
        end
        expect_xlate("lru_touch_a", lru_va(0), page_pa(lru_va(0)), 0);
        expect_xlate("lru_fill_e", lru_va(4), page_pa(lru_va(4)), 2);
        for (i = 0; i < 5; i++) begin
            if (i != 1) begin
                expect_xlate("lru_kept", lru_va(i), page_pa(lru_va(i)), 0);
            end
        end
        expect_xlate("lru_evicted_b", lru_va(1), page_pa(lru_va(1)), 2);
    endtask

    task automatic test_flush();
        expect_xlate("flush_before", VA_4K2, page_pa(VA_4K2), 0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        expect_xlate("flush_after", VA_4K2, page_pa(VA_4K2), 2);
    endtask

    task automatic test_faults();
        expect_fault("fault_invalid", VA_INV, REQ_LIMIT);
        expect_fault("fault_misaligned", VA_MIS, REQ_LIMIT);
        mem_on = 1'b0;                 // memory goes silent.
        expect_fault("fault_timeout", VA_TMO, 2 * `MMU_WALK_TIMEOUT);
        assert (res_edges > `MMU_WALK_TIMEOUT)
            else fail_now("timeout fault came before the walk timeout elapsed");
        mem_on = 1'b1;
        expect_fault("fault_invalid_again", VA_INV, REQ_LIMIT);
        expect_fault("fault_misaligned_again", VA_MIS, REQ_LIMIT);
        expect_fault("fault_timeout_again", VA_TMO, REQ_LIMIT);
    endtask

    initial begin
        rstn   = 1'b0;
        req    = 1'b0;
        vaddr  = '0;
        ptbr   = ROOT_PPN;
        flush  = 1'b0;
        mem_on = 1'b1;
        build_tables();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        test_reset_first_miss();
        test_walk_hit();
        test_superpage();
        test_lru();
        test_flush();
        test_faults();
        @(negedge clk);
        if (u_dut.u_checker.fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end
        else begin
            fail_now("bound checker reported assertion failures");
        end
    end

endmodule

// File: test/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime HALF_PERIOD = 20ns;    // 40 ns period.

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule
